/* compile.f */
rtl/sbit_router_pkg.sv
rtl/sbit_cfg_regs.sv
rtl/vfat_activity_stage.sv
rtl/sbit_partition_stage.sv
rtl/ext_sbit_mux.sv
rtl/sbit_router_top.sv
bench/sbit_router_tb.sv

/* Makefile */
# Verilator build for the trigger-output router
VERILATOR  ?= verilator
FILELIST   ?= compile.f
TB_TOP     ?= sbit_router_tb
RTL_TOP    ?= sbit_router_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/sbit_router_tb.sv */
// --------------------
// Testbench for the trigger-output router. Programs the registers over
// AXI4-Lite, drives chip patterns from a table and checks every line
// --------------------

`timescale 1ns/100ps
`default_nettype none

module sbit_router_tb import sbit_router_pkg::*; ();

  localparam int clk_period       = 100;
  localparam int drive_delay      = 10;
  localparam int pats_per_entry   = 8;
  // Three writes plus one pattern run, with room to spare
  localparam int cycles_per_entry = 40;
  localparam int extra_cycles     = 200;
  localparam int num_tests        = 10;

  typedef struct packed {
    logic [data_w-1:0]    cfg_lo;
    logic [data_w-1:0]    cfg_hi;
    logic [num_vfats-1:0] mask;
    logic                 is_random;
    logic [num_vfats-1:0] pattern;
  } test_entry_t;

  // Config byte is {pad, mode, sel}, so 0x20 is eta and 0x40 is sector
  localparam test_entry_t test_table [num_tests] = '{
    '{32'h03020100, 32'h07060504, 24'hFFFFFF, 1'b1, 24'h0},
    '{32'h0B0A0908, 32'h0F0E0D0C, 24'hFFFFFF, 1'b1, 24'h0},
    '{32'h13121110, 32'h17161514, 24'hFFFFFF, 1'b1, 24'h0},
    // Chip selects 24 to 31 read 0
    '{32'h1B1A1918, 32'h1F1E1D1C, 24'hFFFFFF, 1'b1, 24'h0},
    '{32'h23222120, 32'h27262524, 24'hFFF0FF, 1'b1, 24'h0},
    // Eta selects 8 to 11 out of range
    '{32'h27262524, 32'h2B2A2928, 24'hFFFFFF, 1'b1, 24'h0},
    // Sectors, then selects 6 and 31
    '{32'h43424140, 32'h5F464544, 24'hF0FFFF, 1'b1, 24'h0},
    '{32'h230C4160, 32'h04271745, 24'h0F0F0F, 1'b1, 24'h0},
    // All chips masked so nothing may reach a line
    '{32'h20400005, 32'h47222117, 24'h000000, 1'b0, 24'hFFFFFF},
    '{32'h17004020, 32'h01274560, 24'h800001, 1'b0, 24'hFFFFFF}
  };

  logic                 clock;
  logic                 reset;
  logic [addr_w-1:0]    awaddr_i;
  logic                 awvalid_i;
  logic                 awready_o;
  logic [data_w-1:0]    wdata_i;
  logic [data_w/8-1:0]  wstrb_i;
  logic                 wvalid_i;
  logic                 wready_o;
  logic [1:0]           bresp_o;
  logic                 bvalid_o;
  logic                 bready_i;
  logic [addr_w-1:0]    araddr_i;
  logic                 arvalid_i;
  logic                 arready_o;
  logic [data_w-1:0]    rdata_o;
  logic [1:0]           rresp_o;
  logic                 rvalid_o;
  logic                 rready_i;
  logic [num_vfats-1:0] active_vfats_i;
  logic [num_out-1:0]   ext_sbits_o;

  // Register contents as the bus has set them
  cfg_word_u            shadow_lo;
  cfg_word_u            shadow_hi;
  logic [num_vfats-1:0] shadow_mask;
  logic [31:0]          lcg_state;

  sbit_router_top dut0 (.*);

  always #(clk_period / 2) clock = ~clock;

  // --------------------
  task automatic end_in_failure();
    $display("sim failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic flag_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    end_in_failure();
  endtask

  task automatic flag_protocol_error(input string msg);
    $display("Protocol error at %0t ns: %s", $time, msg);
    end_in_failure();
  endtask

  // Next edge, then the drive point just after it
  task automatic step();
    @(posedge clock);
    #(drive_delay);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0]   old_word,
                                                    input logic [data_w-1:0]   new_word,
                                                    input logic [data_w/8-1:0] strb);
    logic [data_w-1:0] result;
    for (int b = 0; b < data_w / 8; b++) begin
      result[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

  // Reference model of the whole router for one chip pattern
  function automatic logic [num_out-1:0] expected_lines(input logic [num_vfats-1:0] pat,
                                                        input logic [num_vfats-1:0] mask,
                                                        input cfg_word_u lo,
                                                        input cfg_word_u hi);
    logic [num_vfats-1:0]   chips;
    logic [num_eta-1:0]     eta;
    logic [num_sectors-1:0] sector;
    logic [num_out-1:0]     lines;
    chan_cfg_t              ch;
    chips  = pat & mask;
    eta    = '0;
    sector = '0;
    lines  = '0;
    for (int v = 0; v < num_vfats; v++) begin
      eta[v % num_eta] = eta[v % num_eta] | chips[v];
      sector[v / vfats_per_sector] = sector[v / vfats_per_sector] | chips[v];
    end
    for (int n = 0; n < num_out; n++) begin
      ch = (n < cfg_lanes) ? lo.lane[n] : hi.lane[n - cfg_lanes];
      case (ch.mode)
        mode_vfat:   if (int'(ch.sel) < num_vfats) lines[n] = chips[ch.sel];
        mode_eta:    if (int'(ch.sel) < num_eta) lines[n] = eta[ch.sel[2:0]];
        mode_sector: if (int'(ch.sel) < num_sectors) lines[n] = sector[ch.sel[2:0]];
        default:     lines[n] = 1'b0;
      endcase
    end
    return lines;
  endfunction

  // --------------------
  // AXI4-Lite master. The hold argument counts the cycles the response is refused
  task automatic axi_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           input logic [data_w/8-1:0] strb, input int hold,
                           input logic [1:0] exp_resp);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    while (!(awready_o && wready_o)) step();
    step();
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) step();
    assert (bresp_o == exp_resp)
      else flag_mismatch($sformatf("bresp %0d at offset %h, expected %0d",
                                   bresp_o, addr, exp_resp));
    // A second write offered meanwhile must wait
    for (int h = 0; h < hold; h++) begin
      awvalid_i = 1'b1;
      wvalid_i  = 1'b1;
      step();
      assert (bvalid_o && !awready_o && !wready_o)
        else flag_protocol_error("write accepted or bvalid dropped while bready low");
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    bready_i  = 1'b1;
    step();
    bready_i  = 1'b0;
    assert (!bvalid_o) else flag_protocol_error("bvalid still high after the B handshake");
  endtask

  task automatic axi_read(input logic [addr_w-1:0] addr, input int hold,
                          input logic [1:0] exp_resp, output logic [data_w-1:0] data);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    while (!arready_o) step();
    step();
    arvalid_i = 1'b0;
    while (!rvalid_o) step();
    assert (rresp_o == exp_resp)
      else flag_mismatch($sformatf("rresp %0d at offset %h, expected %0d",
                                   rresp_o, addr, exp_resp));
    data = rdata_o;
    for (int h = 0; h < hold; h++) begin
      arvalid_i = 1'b1;
      step();
      assert (rvalid_o && !arready_o)
        else flag_protocol_error("read accepted or rvalid dropped while rready low");
    end
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    step();
    rready_i  = 1'b0;
    assert (!rvalid_o) else flag_protocol_error("rvalid still high after the R handshake");
  endtask

  task automatic check_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] expected,
                           input logic [1:0] exp_resp);
    logic [data_w-1:0] got;
    axi_read(addr, 0, exp_resp, got);
    assert (got == expected)
      else flag_mismatch($sformatf("offset %h read %h, expected %h", addr, got, expected));
  endtask

  // Writes a mapped offset and updates the shadow copy by the strobes
  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                           input logic [data_w/8-1:0] strb);
    logic [data_w-1:0] mask_word;
    axi_write(addr, data, strb, 0, resp_okay);
    mask_word = merge_bytes(data_w'(shadow_mask), data, strb);
    case (addr)
      reg_cfg_lo: shadow_lo.raw = merge_bytes(shadow_lo.raw, data, strb);
      reg_cfg_hi: shadow_hi.raw = merge_bytes(shadow_hi.raw, data, strb);
      default:    shadow_mask = mask_word[num_vfats-1:0];
    endcase
  endtask

  // One pattern per cycle with each checked pipe_latency cycles later
  task automatic run_patterns(input int count, input logic use_random,
                              input logic [num_vfats-1:0] fixed_pat);
    logic [num_vfats-1:0] pat;
    logic [num_out-1:0]   expv;
    logic [num_out-1:0]   exp_q[$];
    for (int i = 0; i < count + pipe_latency; i++) begin
      if (i >= pipe_latency) begin
        expv = exp_q.pop_front();
        assert (ext_sbits_o == expv)
          else flag_mismatch($sformatf("ext_sbits %h, expected %h", ext_sbits_o, expv));
      end
      if (i < count) begin
        if (use_random) begin
          lcg_state = lcg_next(lcg_state);
          pat = lcg_state[31:8];
        end else begin
          pat = fixed_pat;
        end
        active_vfats_i = pat;
        exp_q.push_back(expected_lines(pat, shadow_mask, shadow_lo, shadow_hi));
      end else begin
        active_vfats_i = '0;
      end
      step();
    end
  endtask

  // --------------------
  initial begin
    logic [data_w-1:0] rd_data;
    cfg_word_u         rd_cfg;
    clock          = 1'b0;
    reset          = 1'b1;
    awaddr_i       = '0;
    awvalid_i      = 1'b0;
    wdata_i        = '0;
    wstrb_i        = '0;
    wvalid_i       = 1'b0;
    bready_i       = 1'b0;
    araddr_i       = '0;
    arvalid_i      = 1'b0;
    rready_i       = 1'b0;
    active_vfats_i = '0;
    // Every lane mode_off with sel 0, every chip enabled
    shadow_lo.raw  = 32'h60606060;
    shadow_hi.raw  = 32'h60606060;
    shadow_mask    = '1;
    lcg_state      = 32'h1f2b;
    repeat (2) @(posedge clock);
    #(drive_delay);
    reset = 1'b0;

    assert (ext_sbits_o == '0)
      else flag_mismatch($sformatf("ext_sbits %h after reset, expected 0", ext_sbits_o));
    assert (!awready_o && !wready_o && !bvalid_o && !arready_o && !rvalid_o)
      else flag_protocol_error("handshake outputs not idle after reset");
    for (int w = 0; w < 2; w++) begin
      axi_read(w ? reg_cfg_hi : reg_cfg_lo, 0, resp_okay, rd_data);
      rd_cfg.raw = rd_data;
      for (int n = 0; n < cfg_lanes; n++) begin
        assert (rd_cfg.lane[n].mode == mode_off)
          else flag_mismatch($sformatf("config word %0d lane %0d mode %0d after reset",
                                       w, n, rd_cfg.lane[n].mode));
      end
    end
    check_reg(reg_mask, 32'h00FFFFFF, resp_okay);

    for (int t = 0; t < num_tests; t++) begin
      write_reg(reg_cfg_lo, test_table[t].cfg_lo, 4'hF);
      write_reg(reg_cfg_hi, test_table[t].cfg_hi, 4'hF);
      write_reg(reg_mask, data_w'(test_table[t].mask), 4'hF);
      run_patterns(pats_per_entry, test_table[t].is_random, test_table[t].pattern);
    end

    // Byte 2 of the mask and byte 1 of the low word only
    write_reg(reg_mask, 32'hFF5A0000, 4'b0100);
    write_reg(reg_cfg_lo, 32'hFFFF41FF, 4'b0010);
    check_reg(reg_mask, 32'h005A0001, resp_okay);
    check_reg(reg_cfg_lo, 32'h17004120, resp_okay);
    run_patterns(pats_per_entry, 1'b1, '0);

    // Unmapped offset
    axi_write(4'hC, 32'hFFFFFFFF, 4'hF, 0, resp_slverr);
    check_reg(4'hC, '0, resp_slverr);
    check_reg(reg_cfg_lo, shadow_lo.raw, resp_okay);
    check_reg(reg_cfg_hi, shadow_hi.raw, resp_okay);
    check_reg(reg_mask, data_w'(shadow_mask), resp_okay);

    // Responses held back by the master
    axi_write(reg_cfg_hi, shadow_hi.raw, 4'hF, 4, resp_okay);
    axi_read(reg_cfg_hi, 4, resp_okay, rd_data);
    assert (rd_data == shadow_hi.raw)
      else flag_mismatch($sformatf("held read %h, expected %h", rd_data, shadow_hi.raw));

    $display("sim passed");
    $finish;
  end

  // Watchdog
  initial begin
    #((num_tests * cycles_per_entry + extra_cycles) * clk_period);
    $display("Timeout: the run did not complete within %0d cycles",
             num_tests * cycles_per_entry + extra_cycles);
    end_in_failure();
  end

endmodule

`default_nettype wire

/* rtl/sbit_router_top.sv */
// --------------------
// Trigger-output router top. Register block beside a three stage
// pipeline from chip activity bits to the external lines
// --------------------

`timescale 1ns/100ps
`default_nettype none

module sbit_router_top import sbit_router_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // AXI4-Lite slave
  input  logic [addr_w-1:0]    awaddr_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  logic [data_w-1:0]    wdata_i,
  input  logic [data_w/8-1:0]  wstrb_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output logic [1:0]           bresp_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  input  logic [addr_w-1:0]    araddr_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output logic [data_w-1:0]    rdata_o,
  output logic [1:0]           rresp_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  // Trigger path
  input  logic [num_vfats-1:0] active_vfats_i,
  output logic [num_out-1:0]   ext_sbits_o
);

  cfg_word_u              cfg_lo;
  cfg_word_u              cfg_hi;
  logic [num_vfats-1:0]   vfat_mask;
  logic [num_vfats-1:0]   vfat_bits_s1;
  logic [num_vfats-1:0]   vfat_bits_s2;
  logic [num_eta-1:0]     eta_bits;
  logic [num_sectors-1:0] sector_bits;

  sbit_cfg_regs regs0 (
    .clock, .reset,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .cfg_lo_o    (cfg_lo),
    .cfg_hi_o    (cfg_hi),
    .vfat_mask_o (vfat_mask)
  );

  // Mask, reduce, select
  vfat_activity_stage act0 (
    .clock, .reset,
    .active_vfats_i,
    .vfat_mask_i (vfat_mask),
    .vfat_bits_o (vfat_bits_s1)
  );

  sbit_partition_stage part0 (
    .clock, .reset,
    .vfat_bits_i   (vfat_bits_s1),
    .vfat_bits_o   (vfat_bits_s2),
    .eta_bits_o    (eta_bits),
    .sector_bits_o (sector_bits)
  );

  ext_sbit_mux mux0 (
    .clock, .reset,
    .vfat_bits_i   (vfat_bits_s2),
    .eta_bits_i    (eta_bits),
    .sector_bits_i (sector_bits),
    .cfg_lo_i      (cfg_lo),
    .cfg_hi_i      (cfg_hi),
    .ext_sbits_o
  );

endmodule

`default_nettype wire

/* rtl/ext_sbit_mux.sv */
// --------------------
// Last pipeline stage. Each output line picks one chip, eta or sector
// bit by its mode and select, and registers it
// --------------------

`timescale 1ns/100ps
`default_nettype none

module ext_sbit_mux import sbit_router_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [num_vfats-1:0]   vfat_bits_i,
  input  logic [num_eta-1:0]     eta_bits_i,
  input  logic [num_sectors-1:0] sector_bits_i,
  input  cfg_word_u              cfg_lo_i,
  input  cfg_word_u              cfg_hi_i,
  output logic [num_out-1:0]     ext_sbits_o
);

  chan_cfg_t [num_out-1:0] chan;
  logic [sel_span-1:0]     vfat_ext;
  logic [sel_span-1:0]     eta_ext;
  logic [sel_span-1:0]     sector_ext;
  logic [num_out-1:0]      pick;

  // Lines 0..3 from the low word, 4..7 from the high word
  assign chan = {cfg_hi_i.lane, cfg_lo_i.lane};

  // Zero padding above each source covers the out-of-range selects
  assign vfat_ext   = sel_span'(vfat_bits_i);
  assign eta_ext    = sel_span'(eta_bits_i);
  assign sector_ext = sel_span'(sector_bits_i);

  always_comb begin
    for (int n = 0; n < num_out; n++) begin
      case (chan[n].mode)
        mode_vfat:   pick[n] = vfat_ext[chan[n].sel];
        mode_eta:    pick[n] = eta_ext[chan[n].sel];
        mode_sector: pick[n] = sector_ext[chan[n].sel];
        default:     pick[n] = 1'b0;
      endcase
    end
  end

  // Edge 3
  always_ff @(posedge clock) begin
    if (reset) begin
      ext_sbits_o <= '0;
    end else begin
      ext_sbits_o <= pick;
    end
  end

  // --------------------
  // A line switched off or pointed past the end of its source goes quiet one cycle later
  for (genvar n = 0; n < num_out; n++) begin : g_off_chk
    line_off_a : assert property (@(posedge clock) disable iff (reset)
      chan[n].mode == mode_off
      || (chan[n].mode == mode_vfat && int'(chan[n].sel) >= num_vfats)
      || (chan[n].mode == mode_eta && int'(chan[n].sel) >= num_eta)
      || (chan[n].mode == mode_sector && int'(chan[n].sel) >= num_sectors)
      |=> !ext_sbits_o[n]);
  end

endmodule

`default_nettype wire

/* rtl/sbit_partition_stage.sv */
// --------------------
// Second pipeline stage. Reduces the chip bits into eta partitions and
// sectors, and carries a delayed copy of the chip bits alongside
// --------------------

`timescale 1ns/100ps
`default_nettype none

module sbit_partition_stage import sbit_router_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [num_vfats-1:0]   vfat_bits_i,
  output logic [num_vfats-1:0]   vfat_bits_o,
  output logic [num_eta-1:0]     eta_bits_o,
  output logic [num_sectors-1:0] sector_bits_o
);

  logic [num_eta-1:0]     eta_or;
  logic [num_sectors-1:0] sector_or;

  // Eta partition k collects chips k, k+8, k+16
  always_comb begin
    eta_or = '0;
    for (int k = 0; k < num_eta; k++) begin
      for (int c = k; c < num_vfats; c += num_eta) begin
        eta_or[k] = eta_or[k] | vfat_bits_i[c];
      end
    end
  end

  // Sector s is four adjacent chips
  always_comb begin
    for (int s = 0; s < num_sectors; s++) begin
      sector_or[s] = |vfat_bits_i[s*vfats_per_sector +: vfats_per_sector];
    end
  end

  // --------------------
  // Edge 2 registers all three views from the same sample
  always_ff @(posedge clock) begin
    if (reset) begin
      vfat_bits_o   <= '0;
      eta_bits_o    <= '0;
      sector_bits_o <= '0;
    end else begin
      vfat_bits_o   <= vfat_bits_i;
      eta_bits_o    <= eta_or;
      sector_bits_o <= sector_or;
    end
  end

endmodule

`default_nettype wire

/* rtl/vfat_activity_stage.sv */
// --------------------
// First pipeline stage. Masks the per-chip activity bits so noisy
// chips can be silenced, and registers the result
// --------------------

`timescale 1ns/100ps
`default_nettype none

module vfat_activity_stage import sbit_router_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [num_vfats-1:0] active_vfats_i,
  input  logic [num_vfats-1:0] vfat_mask_i,
  output logic [num_vfats-1:0] vfat_bits_o
);

  logic [num_vfats-1:0] masked;

  // Mask bit low drops that chip from every mode downstream
  assign masked = active_vfats_i & vfat_mask_i;

  // Edge 1 of the pipeline
  always_ff @(posedge clock) begin
    if (reset) begin
      vfat_bits_o <= '0;
    end else begin
      vfat_bits_o <= masked;
    end
  end

endmodule

`default_nettype wire

/* rtl/sbit_cfg_regs.sv */
// --------------------
// AXI4-Lite slave with the two channel config words and the chip mask.
// One write and one read in flight at most; responses wait for the master
// --------------------

`timescale 1ns/100ps
`default_nettype none

module sbit_cfg_regs import sbit_router_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // Write address and data
  input  logic [addr_w-1:0]    awaddr_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  logic [data_w-1:0]    wdata_i,
  input  logic [data_w/8-1:0]  wstrb_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  // Write response
  output logic [1:0]           bresp_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  // Read address and data
  input  logic [addr_w-1:0]    araddr_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output logic [data_w-1:0]    rdata_o,
  output logic [1:0]           rresp_o,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  // Configuration to the pipeline
  output cfg_word_u            cfg_lo_o,
  output cfg_word_u            cfg_hi_o,
  output logic [num_vfats-1:0] vfat_mask_o
);

  logic                 wr_pend;
  logic                 wr_done;
  logic [addr_w-1:0]    wr_addr;
  logic [data_w-1:0]    wr_data;
  logic [data_w/8-1:0]  wr_strb;
  logic [data_w-1:0]    mask_merged;
  logic                 rd_pend;
  logic [addr_w-1:0]    rd_addr;
  logic [data_w-1:0]    rd_word;

  // Replace only the strobed bytes of old_word
  function automatic logic [data_w-1:0] strobe_merge(input logic [data_w-1:0]   old_word,
                                                     input logic [data_w-1:0]   new_word,
                                                     input logic [data_w/8-1:0] strb);
    logic [data_w-1:0] merged;
    merged = old_word;
    for (int b = 0; b < data_w / 8; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  // --------------------
  // Write channel
  // AW and W accepted together, then commit, then B
  always_ff @(posedge clock) begin
    if (reset) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      wr_pend   <= 1'b0;
      wr_done   <= 1'b0;
      bvalid_o  <= 1'b0;
    end else begin
      awready_o <= awvalid_i && wvalid_i && !bvalid_o && !awready_o && !wr_pend && !wr_done;
      wready_o  <= awvalid_i && wvalid_i && !bvalid_o && !awready_o && !wr_pend && !wr_done;
      wr_pend   <= awready_o && awvalid_i;
      wr_done   <= wr_pend;
      if (wr_done) bvalid_o <= 1'b1;
      else if (bvalid_o && bready_i) bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (awready_o && awvalid_i) begin
      wr_addr <= awaddr_i;
      wr_data <= wdata_i;
      wr_strb <= wstrb_i;
    end
    if (wr_pend) begin
      bresp_o <= (wr_addr inside {reg_cfg_lo, reg_cfg_hi, reg_mask}) ? resp_okay : resp_slverr;
    end
  end

  // Mask upper byte has no storage
  assign mask_merged = strobe_merge(data_w'(vfat_mask_o), wr_data, wr_strb);

  always_ff @(posedge clock) begin
    if (reset) begin
      // All lines off, every chip enabled
      for (int n = 0; n < cfg_lanes; n++) begin
        cfg_lo_o.lane[n] <= '{pad: 1'b0, mode: mode_off, sel: '0};
        cfg_hi_o.lane[n] <= '{pad: 1'b0, mode: mode_off, sel: '0};
      end
      vfat_mask_o <= '1;
    end else if (wr_pend) begin
      case (wr_addr)
        reg_cfg_lo: cfg_lo_o.raw <= strobe_merge(cfg_lo_o.raw, wr_data, wr_strb);
        reg_cfg_hi: cfg_hi_o.raw <= strobe_merge(cfg_hi_o.raw, wr_data, wr_strb);
        reg_mask:   vfat_mask_o  <= mask_merged[num_vfats-1:0];
        default:    ;
      endcase
    end
  end

  // --------------------
  // Read channel
  always_ff @(posedge clock) begin
    if (reset) begin
      arready_o <= 1'b0;
      rd_pend   <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      arready_o <= arvalid_i && !rvalid_o && !arready_o && !rd_pend;
      rd_pend   <= arready_o && arvalid_i;
      if (rd_pend) rvalid_o <= 1'b1;
      else if (rvalid_o && rready_i) rvalid_o <= 1'b0;
    end
  end

  always_comb begin
    case (rd_addr)
      reg_cfg_lo: rd_word = cfg_lo_o.raw;
      reg_cfg_hi: rd_word = cfg_hi_o.raw;
      reg_mask:   rd_word = data_w'(vfat_mask_o);
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (arready_o && arvalid_i) rd_addr <= araddr_i;
    if (rd_pend) begin
      rdata_o <= rd_word;
      rresp_o <= (rd_addr inside {reg_cfg_lo, reg_cfg_hi, reg_mask}) ? resp_okay : resp_slverr;
    end
  end

  // Responses and their payload held until the master takes them
  bvalid_held_a : assert property (@(posedge clock) disable iff (reset)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));
  rvalid_held_a : assert property (@(posedge clock) disable iff (reset)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

`default_nettype wire

/* rtl/sbit_router_pkg.sv */
// --------------------
// Shared sizes, mode codes, register map and config word layout of the
// trigger-output router. Imported by every router module and the testbench
// --------------------

`default_nettype none

package sbit_router_pkg;

  // Chamber geometry
  localparam int num_vfats        = 24;
  localparam int num_out          = 8;
  localparam int num_eta          = 8;
  localparam int num_sectors      = 6;
  localparam int vfats_per_sector = 4;

  // Per-line selection fields
  localparam int sel_w    = 5;
  localparam int mode_w   = 2;
  // Every source is zero extended to this span, so a large sel reads 0
  localparam int sel_span = 1 << sel_w;

  localparam logic [mode_w-1:0] mode_vfat   = 2'd0;
  localparam logic [mode_w-1:0] mode_eta    = 2'd1;
  localparam logic [mode_w-1:0] mode_sector = 2'd2;
  localparam logic [mode_w-1:0] mode_off    = 2'd3;

  // --------------------
  // AXI4-Lite register map
  localparam int addr_w    = 4;
  localparam int data_w    = 32;
  localparam int cfg_lanes = data_w / 8;

  localparam logic [addr_w-1:0] reg_cfg_lo = 4'h0;
  localparam logic [addr_w-1:0] reg_cfg_hi = 4'h4;
  localparam logic [addr_w-1:0] reg_mask   = 4'h8;

  localparam logic [1:0] resp_okay   = 2'd0;
  localparam logic [1:0] resp_slverr = 2'd2;

  // Cycles from active_vfats_i to ext_sbits_o
  localparam int pipe_latency = 3;

  // One byte of a config word, one output line
  typedef struct packed {
    logic              pad;
    logic [mode_w-1:0] mode;
    logic [sel_w-1:0]  sel;
  } chan_cfg_t;

  // Raw view for the bus and byte strobes, lane view for the lines
  typedef union packed {
    logic [data_w-1:0]               raw;
    chan_cfg_t [cfg_lanes-1:0]       lane;
  } cfg_word_u;

endpackage

`default_nettype wire
